// ==== src.f ====
design/tlbPkg.sv
design/memAccessPkg.sv
design/accessSplitter.sv
design/tlbLookupLane.sv
design/responseMerger.sv
design/alignTop.sv
sim/alignTb_asserts.sv
sim/alignTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module alignTb -f src.f

status=0
output=$(./obj_dir/ValignTb +verilator+error+limit+100 2>&1) || status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
printf '%s\n' "$output" | grep -q "All tests passed"

// ==== sim/alignTb.sv ====
module alignTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TLB_ENTRIES = 8;
    localparam int QUEUE_DEPTH = 4;
    localparam int TIMEOUT     = 200;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     reqValid;
    memAccessPkg::accessReqT  req;
    logic                     reqCredit;
    logic                     tlbWrEn;
    tlbPkg::tlbIndexT         tlbWrIdx;
    tlbPkg::tlbEntryT         tlbWrEntry;
    logic                     respValid;
    memAccessPkg::accessRespT resp;
    logic                     respCredit;

    // testbench copy of the TLB contents
    tlbPkg::tlbEntryT         tlbModel [TLB_ENTRIES];
    memAccessPkg::accessRespT expQueue [$];
    int                       reqCredits;
    int                       creditPulses;
    int                       respSeen;
    int                       granted;
    integer                   seed = 32'h2d45_123e;

    alignTop #(
        .TLB_ENTRIES (TLB_ENTRIES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .req        (req),
        .reqCredit  (reqCredit),
        .tlbWrEn    (tlbWrEn),
        .tlbWrIdx   (tlbWrIdx),
        .tlbWrEntry (tlbWrEntry),
        .respValid  (respValid),
        .resp       (resp),
        .respCredit (respCredit)
    );

    always #5 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s: got %0h, expected %0h", name, actual, expected));
        end
    endtask

    task automatic checkResp(input memAccessPkg::accessRespT e);
        checkEq("resp.paddr0", 128'(resp.paddr0), 128'(e.paddr0));
        checkEq("resp.paddr1", 128'(resp.paddr1), 128'(e.paddr1));
        checkEq("resp.mask0", 128'(resp.mask0), 128'(e.mask0));
        checkEq("resp.mask1", 128'(resp.mask1), 128'(e.mask1));
        checkEq("resp.data0", resp.data0, e.data0);
        checkEq("resp.data1", resp.data1, e.data1);
        // crossesLine, tlbMiss, protFault, uncacheable
        checkEq("resp.flags", 128'(resp[3:0]), 128'(e[3:0]));
    endtask

    function automatic int findEntry(input tlbPkg::vpnT vpn);
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (tlbModel[i].valid && tlbModel[i].vpn == vpn) return i;
        end
        return -1;
    endfunction

    function automatic memAccessPkg::accessRespT expectResp(input memAccessPkg::accessReqT r);
        memAccessPkg::accessRespT e;
        memAccessPkg::vaddrT      va;
        tlbPkg::paddrT            pa;
        int                       offset;
        int                       count;
        int                       pos;
        int                       idx;
        e = '0;
        offset = int'(r.addr[3:0]);
        count = 1 << r.size;
        e.crossesLine = (offset + count) > memAccessPkg::LINE_BYTES;
        // all eight store bytes move with the offset while the mask only covers the access
        for (int b = 0; b < 8; b++) begin
            pos = offset + b;
            if (pos < 16) begin
                e.data0[pos*8 +: 8] = r.storeData[b*8 +: 8];
                e.mask0[pos] = (b < count);
            end else if (e.crossesLine) begin
                e.data1[(pos-16)*8 +: 8] = r.storeData[b*8 +: 8];
                e.mask1[pos-16] = (b < count);
            end
        end
        for (int l = 0; l < 2; l++) begin
            va = {r.addr[31:4], 4'h0} + 32'(16 * l);
            idx = findEntry(va[31:12]);
            if (l == 0 || e.crossesLine) begin
                if (idx < 0) begin
                    e.tlbMiss = 1'b1;
                end else begin
                    pa = {tlbModel[idx].pfn, va[11:0]};
                    if (l == 0) begin
                        e.paddr0 = pa;
                    end else begin
                        e.paddr1 = pa;
                    end
                    e.protFault = e.protFault | (r.isWrite & ~tlbModel[idx].writable);
                    e.uncacheable = e.uncacheable | tlbModel[idx].uncacheable;
                end
            end
        end
        return e;
    endfunction

    // one clock step; outputs are looked at once they have settled
    task automatic tick();
        @(posedge clk);
        #1;
        reqValid   = 1'b0;
        respCredit = 1'b0;
        tlbWrEn    = 1'b0;
        if (reqCredit) begin
            reqCredits++;
            creditPulses++;
        end
        if (respValid && expQueue.size() == 0) begin
            failRun("a response arrived with no request outstanding");
        end else if (respValid) begin
            checkResp(expQueue.pop_front());
            respSeen++;
        end
    endtask

    task automatic waitForCredits(input int need);
        int cycles;
        cycles = 0;
        while (reqCredits < need) begin
            tick();
            cycles++;
            if (cycles > TIMEOUT) failRun("timed out waiting for a reqCredit pulse");
        end
    endtask

    task automatic issue(input memAccessPkg::accessReqT r);
        reqValid = 1'b1;
        req = r;
        reqCredits--;
        expQueue.push_back(expectResp(r));
    endtask

    task automatic sendReq(input memAccessPkg::vaddrT addr, input memAccessPkg::accessSizeT size,
                           input logic isWrite, input memAccessPkg::storeDataT data);
        waitForCredits(1);
        issue({addr, size, isWrite, data});
        tick();
    endtask

    // grant just enough response credits to empty the queue
    task automatic drainAll();
        int cycles;
        cycles = 0;
        while (expQueue.size() != 0) begin
            if (granted - respSeen < expQueue.size()) begin
                respCredit = 1'b1;
                granted++;
            end
            tick();
            cycles++;
            if (cycles > TIMEOUT) failRun("timed out waiting for respValid");
        end
    endtask

    task automatic roundTrip(input memAccessPkg::vaddrT addr, input memAccessPkg::accessSizeT size,
                             input logic isWrite, input memAccessPkg::storeDataT data);
        sendReq(addr, size, isWrite, data);
        drainAll();
    endtask

    task automatic writeTlb(input int idx, input tlbPkg::tlbEntryT entry);
        tlbWrEn = 1'b1;
        tlbWrIdx = 3'(idx);
        tlbWrEntry = entry;
        tlbModel[idx] = entry;
        tick();
    endtask

    task automatic alignedAccesses();
        roundTrip(32'h0001_0040, 2'd3, 1'b1, 64'h1122_3344_5566_7788);
        roundTrip(32'h0001_0104, 2'd2, 1'b0, 64'h0bad_cafe_dead_beef);
        roundTrip(32'h0001_020f, 2'd0, 1'b1, 64'h0000_0000_0000_00a5);
    endtask

    task automatic lineCrossings();
        roundTrip(32'h0001_003c, 2'd3, 1'b1, 64'h8877_6655_4433_2211);
        // also crosses into the next page and onto another frame
        roundTrip(32'h0001_0ffa, 2'd3, 1'b1, 64'hfeed_f00d_1357_9bdf);
        roundTrip(32'h0001_002f, 2'd1, 1'b0, 64'h0000_0000_0000_c3d4);
    endtask

    task automatic translationFlags();
        roundTrip(32'h0005_0100, 2'd2, 1'b0, 64'h0);
        // second line falls in an unmapped page
        roundTrip(32'h0001_1ffc, 2'd3, 1'b0, 64'h0);
        roundTrip(32'h0002_0010, 2'd2, 1'b1, 64'h0000_0000_5a5a_a5a5);
        roundTrip(32'h0002_0010, 2'd2, 1'b0, 64'h0);
        roundTrip(32'h0003_1020, 2'd3, 1'b0, 64'h0);
        roundTrip(32'h0003_0ffc, 2'd3, 1'b0, 64'h0);
    endtask

    task automatic backPressure();
        int pulsesBefore;
        int seenBefore;
        waitForCredits(QUEUE_DEPTH);
        pulsesBefore = creditPulses;
        seenBefore = respSeen;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            sendReq(32'h0001_0000 + 32'(i * 24), 2'(i), i[0], {$random(seed), $random(seed)});
        end
        // no response credit yet, so nothing may come out
        repeat (20) tick();
        checkEq("respValid pulses", 128'(respSeen - seenBefore), 128'(0));
        checkEq("reqCredit pulses", 128'(creditPulses - pulsesBefore), 128'(0));
        drainAll();
        waitForCredits(QUEUE_DEPTH);
        // room for any extra pulse to show up
        repeat (4) tick();
        checkEq("reqCredit pulses", 128'(creditPulses - pulsesBefore), 128'(QUEUE_DEPTH));
    endtask

    task automatic randomTraffic();
        memAccessPkg::accessReqT r;
        logic [31:0]             rnd;
        tlbPkg::vpnT             pages [6];
        pages = '{20'h00010, 20'h00011, 20'h00020, 20'h00030, 20'h00031, 20'h00050};
        for (int i = 0; i < 400; i++) begin
            rnd = $random(seed);
            if (rnd[0] && reqCredits > 0) begin
                r.addr = {pages[int'(rnd[31:17]) % 6], rnd[16:5]};
                r.size = rnd[4:3];
                r.isWrite = rnd[2];
                r.storeData = {$random(seed), $random(seed)};
                issue(r);
            end
            if (rnd[1] && granted - respSeen < 8) begin
                respCredit = 1'b1;
                granted++;
            end
            tick();
        end
        drainAll();
    endtask

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        req = '0;
        tlbWrEn = 1'b0;
        tlbWrIdx = '0;
        tlbWrEntry = '0;
        respCredit = 1'b0;
        reqCredits = QUEUE_DEPTH;
        creditPulses = 0;
        respSeen = 0;
        granted = 0;
        foreach (tlbModel[i]) tlbModel[i] = '0;
        repeat (16) tick();
        rst = 1'b0;
        // valid, writable, uncacheable, vpn, pfn
        writeTlb(0, {1'b1, 1'b1, 1'b0, 20'h00010, 8'h21});
        writeTlb(1, {1'b1, 1'b1, 1'b0, 20'h00011, 8'h57});
        writeTlb(2, {1'b1, 1'b0, 1'b0, 20'h00020, 8'h33});
        writeTlb(3, {1'b1, 1'b1, 1'b0, 20'h00030, 8'h44});
        writeTlb(4, {1'b1, 1'b1, 1'b1, 20'h00031, 8'h45});
        alignedAccesses();
        lineCrossings();
        translationFlags();
        backPressure();
        randomTraffic();
        waitForCredits(QUEUE_DEPTH);
        if (uut.merger.asserts.failCount == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            failRun("a bound assertion on the response merger failed");
        end
    end

endmodule

// ==== sim/alignTb_asserts.sv ====
module alignAsserts #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic                             clk,
    input logic                             rst,
    input logic                             respValid,
    input logic                             reqCredit,
    input logic                             laneValid,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0] queueCount
);

    timeunit 1ns;
    timeprecision 1ps;

    // assertion failures so far
    int failCount = 0;

    quietInReset: assert property (@(posedge clk) rst && $past(rst) |-> !respValid)
        else begin
            failCount++;
            $error("respValid high while in reset");
        end

    // a dequeue leaves one entry fewer than the writes alone would
    creditAfterDequeue: assert property (@(posedge clk) disable iff (rst)
        reqCredit == ((int'($past(queueCount)) + int'($past(laneValid))
                       - int'(queueCount)) == 1))
        else begin
            failCount++;
            $error("reqCredit pulse does not match a dequeue in the previous cycle");
        end

    queueBound: assert property (@(posedge clk) disable iff (rst)
        int'(queueCount) <= QUEUE_DEPTH)
        else begin
            failCount++;
            $error("response queue holds more than its depth");
        end

endmodule

bind responseMerger alignAsserts #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) asserts (
    .clk        (clk),
    .rst        (rst),
    .respValid  (respValid),
    .reqCredit  (reqCredit),
    .laneValid  (laneValid),
    .queueCount (queueCount)
);

// ==== design/alignTop.sv ====
module alignTop #(
    parameter int TLB_ENTRIES = 8,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reqValid,
    input  memAccessPkg::accessReqT   req,
    output logic                      reqCredit,
    input  logic                      tlbWrEn,
    input  tlbPkg::tlbIndexT          tlbWrIdx,
    input  tlbPkg::tlbEntryT          tlbWrEntry,
    output logic                      respValid,
    output memAccessPkg::accessRespT  resp,
    input  logic                      respCredit
);

    logic                                splitValid;
    memAccessPkg::lineAccessT            splitAccess [memAccessPkg::LANE_COUNT];
    logic [memAccessPkg::LANE_COUNT-1:0] laneValidVec;
    logic                                laneValid;
    memAccessPkg::laneResultT            laneResult [memAccessPkg::LANE_COUNT];

    accessSplitter splitter (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .req         (req),
        .splitValid  (splitValid),
        .splitAccess (splitAccess)
    );

    // every lane gets the same TLB writes, so the tables stay identical
    for (genvar i = 0; i < memAccessPkg::LANE_COUNT; i++) begin : genLane
        tlbLookupLane #(
            .TLB_ENTRIES (TLB_ENTRIES)
        ) lane (
            .clk        (clk),
            .rst        (rst),
            .tlbWrEn    (tlbWrEn),
            .tlbWrIdx   (tlbWrIdx),
            .tlbWrEntry (tlbWrEntry),
            .inValid    (splitValid),
            .access     (splitAccess[i]),
            .outValid   (laneValidVec[i]),
            .result     (laneResult[i])
        );
    end

    // lanes run in lockstep
    assign laneValid = &laneValidVec;

    responseMerger #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) merger (
        .clk        (clk),
        .rst        (rst),
        .laneValid  (laneValid),
        .laneResult (laneResult),
        .respCredit (respCredit),
        .respValid  (respValid),
        .resp       (resp),
        .reqCredit  (reqCredit)
    );

endmodule

// ==== design/responseMerger.sv ====
module responseMerger #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      laneValid,
    input  memAccessPkg::laneResultT  laneResult [memAccessPkg::LANE_COUNT],
    input  logic                      respCredit,
    output logic                      respValid,
    output memAccessPkg::accessRespT  resp,
    output logic                      reqCredit
);

    localparam int PTR_BITS    = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_BITS  = $clog2(QUEUE_DEPTH + 1);
    localparam int CREDIT_BITS = 8;

    memAccessPkg::accessRespT respQueue [QUEUE_DEPTH];
    memAccessPkg::accessRespT mergedResp;
    logic [PTR_BITS-1:0]      wrPtr;
    logic [PTR_BITS-1:0]      rdPtr;
    logic [COUNT_BITS-1:0]    queueCount;
    logic [CREDIT_BITS-1:0]   respCredits;
    logic                     dequeue;

    always_comb begin
        mergedResp.paddr0      = laneResult[0].paddr;
        mergedResp.paddr1      = laneResult[1].paddr;
        mergedResp.mask0       = laneResult[0].access.mask;
        mergedResp.mask1       = laneResult[1].access.mask;
        mergedResp.data0       = laneResult[0].access.data;
        mergedResp.data1       = laneResult[1].access.data;
        mergedResp.crossesLine = laneResult[1].access.active;
        mergedResp.tlbMiss     = 1'b0;
        mergedResp.protFault   = 1'b0;
        mergedResp.uncacheable = 1'b0;
        // flags only count from lanes that carry part of the access
        for (int i = 0; i < memAccessPkg::LANE_COUNT; i++) begin
            if (laneResult[i].access.active) begin
                mergedResp.tlbMiss     |= !laneResult[i].hit;
                mergedResp.protFault   |= laneResult[i].protFault;
                mergedResp.uncacheable |= laneResult[i].uncacheable;
            end
        end
    end

    // head goes out only when the cache has room for it
    assign respValid = (queueCount != '0) && (respCredits != '0);
    assign resp      = respQueue[rdPtr];
    assign dequeue   = respValid;

    always_ff @(posedge clk) begin
        if (laneValid) begin
            respQueue[wrPtr] <= mergedResp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            queueCount  <= '0;
            respCredits <= '0;
            reqCredit   <= 1'b0;
        end else begin
            if (laneValid) begin
                wrPtr <= (wrPtr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (dequeue) begin
                rdPtr <= (rdPtr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            queueCount  <= queueCount + COUNT_BITS'(laneValid) - COUNT_BITS'(dequeue);
            respCredits <= respCredits + CREDIT_BITS'(respCredit) - CREDIT_BITS'(dequeue);
            // hand the slot back to the requester
            reqCredit   <= dequeue;
        end
    end

endmodule

// ==== design/tlbLookupLane.sv ====
module tlbLookupLane #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      tlbWrEn,
    input  tlbPkg::tlbIndexT          tlbWrIdx,
    input  tlbPkg::tlbEntryT          tlbWrEntry,
    input  logic                      inValid,
    input  memAccessPkg::lineAccessT  access,
    output logic                      outValid,
    output memAccessPkg::laneResultT  result
);

    localparam int VADDR_BITS = $bits(memAccessPkg::vaddrT);

    tlbPkg::tlbEntryT         entryTable [TLB_ENTRIES];
    tlbPkg::vpnT              vpn;
    logic                     hitFound;
    tlbPkg::tlbEntryT         hitEntry;
    memAccessPkg::laneResultT nextResult;

    assign vpn = access.vaddr[VADDR_BITS-1:tlbPkg::PAGE_OFFSET_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entryTable[i] <= '0;
            end
        end else if (tlbWrEn) begin
            entryTable[tlbWrIdx] <= tlbWrEntry;
        end
    end

    // walk downward so the lowest matching index is the one kept
    always_comb begin
        hitFound = 1'b0;
        hitEntry = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entryTable[i].valid && entryTable[i].vpn == vpn) begin
                hitFound = 1'b1;
                hitEntry = entryTable[i];
            end
        end
    end

    always_comb begin
        nextResult.access = access;
        if (!access.active) begin
            // nothing to translate, report a clean hit
            nextResult.paddr       = '0;
            nextResult.hit         = 1'b1;
            nextResult.protFault   = 1'b0;
            nextResult.uncacheable = 1'b0;
        end else begin
            // paddr reads zero on a miss
            nextResult.paddr       = hitFound ?
                {hitEntry.pfn, access.vaddr[tlbPkg::PAGE_OFFSET_BITS-1:0]} : '0;
            nextResult.hit         = hitFound;
            nextResult.protFault   = hitFound && access.isWrite && !hitEntry.writable;
            nextResult.uncacheable = hitFound && hitEntry.uncacheable;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            result <= nextResult;
        end
    end

endmodule

// ==== design/accessSplitter.sv ====
module accessSplitter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reqValid,
    input  memAccessPkg::accessReqT   req,
    output logic                      splitValid,
    output memAccessPkg::lineAccessT  splitAccess [memAccessPkg::LANE_COUNT]
);

    localparam int OFFSET_BITS = $clog2(memAccessPkg::LINE_BYTES);
    localparam int SPAN_BYTES  = 2 * memAccessPkg::LINE_BYTES;
    localparam int SPAN_BITS   = SPAN_BYTES * 8;
    localparam int PAD_BITS    = SPAN_BITS - $bits(memAccessPkg::storeDataT);

    logic [OFFSET_BITS-1:0]   offset;
    logic [OFFSET_BITS:0]     byteCount;
    logic [OFFSET_BITS:0]     endByte;
    logic                     crosses;
    logic [SPAN_BYTES-1:0]    spanMask;
    logic [SPAN_BITS-1:0]     spanData;
    memAccessPkg::vaddrT      lineAddr;
    memAccessPkg::lineAccessT nextAccess [memAccessPkg::LANE_COUNT];

    assign offset    = req.addr[OFFSET_BITS-1:0];
    assign byteCount = (OFFSET_BITS + 1)'(1) << req.size;
    assign endByte   = {1'b0, offset} + byteCount;
    assign crosses   = endByte > (OFFSET_BITS + 1)'(memAccessPkg::LINE_BYTES);
    assign lineAddr  = {req.addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    // mask and data laid out over two consecutive lines
    // upper half is what spills into the next line
    assign spanMask = ((SPAN_BYTES'(1) << byteCount) - SPAN_BYTES'(1)) << offset;
    assign spanData = {{PAD_BITS{1'b0}}, req.storeData} << {offset, 3'b000};

    always_comb begin
        nextAccess[0].active  = 1'b1;
        nextAccess[0].vaddr   = lineAddr;
        nextAccess[0].isWrite = req.isWrite;
        nextAccess[0].mask    = spanMask[memAccessPkg::LINE_BYTES-1:0];
        nextAccess[0].data    = spanData[SPAN_BITS/2-1:0];

        // second lane stays all zero unless the access spills over
        nextAccess[1] = '0;
        if (crosses) begin
            nextAccess[1].active  = 1'b1;
            nextAccess[1].vaddr   = lineAddr + memAccessPkg::vaddrT'(memAccessPkg::LINE_BYTES);
            nextAccess[1].isWrite = req.isWrite;
            nextAccess[1].mask    = spanMask[SPAN_BYTES-1:memAccessPkg::LINE_BYTES];
            nextAccess[1].data    = spanData[SPAN_BITS-1:SPAN_BITS/2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            splitValid <= 1'b0;
        end else begin
            splitValid <= reqValid;
        end
    end

    // payload only moves with a valid request
    always_ff @(posedge clk) begin
        if (reqValid) begin
            for (int i = 0; i < memAccessPkg::LANE_COUNT; i++) begin
                splitAccess[i] <= nextAccess[i];
            end
        end
    end

endmodule

// ==== design/memAccessPkg.sv ====
package memAccessPkg;

    localparam int LINE_BYTES = 16;
    // an access of at most 8 bytes touches at most two lines
    localparam int LANE_COUNT = 2;

    typedef logic [31:0]             vaddrT;
    // 0..3 encode 1, 2, 4, 8 bytes
    typedef logic [1:0]              accessSizeT;
    typedef logic [63:0]             storeDataT;
    typedef logic [LINE_BYTES*8-1:0] lineDataT;
    typedef logic [LINE_BYTES-1:0]   byteMaskT;

    typedef struct packed {
        vaddrT      addr;
        accessSizeT size;
        logic       isWrite;
        storeDataT  storeData;
    } accessReqT;

    // one line-sized piece of a request
    typedef struct packed {
        logic     active;
        vaddrT    vaddr;
        logic     isWrite;
        byteMaskT mask;
        lineDataT data;
    } lineAccessT;

    // line access after translation in one lane
    typedef struct packed {
        lineAccessT    access;
        tlbPkg::paddrT paddr;
        logic          hit;
        logic          protFault;
        logic          uncacheable;
    } laneResultT;

    typedef struct packed {
        tlbPkg::paddrT paddr0;
        tlbPkg::paddrT paddr1;
        byteMaskT      mask0;
        byteMaskT      mask1;
        lineDataT      data0;
        lineDataT      data1;
        logic          crossesLine;
        logic          tlbMiss;
        logic          protFault;
        logic          uncacheable;
    } accessRespT;

endpackage

// ==== design/tlbPkg.sv ====
package tlbPkg;

    // 4 KiB pages
    localparam int PAGE_OFFSET_BITS = 12;

    // translation widths
    typedef logic [19:0] vpnT;
    typedef logic [7:0]  pfnT;
    typedef logic [19:0] paddrT;

    // index into the entry table, sized for the default of 8 entries
    typedef logic [2:0] tlbIndexT;

    typedef struct packed {
        logic valid;
        logic writable;
        logic uncacheable;
        vpnT  vpn;
        pfnT  pfn;
    } tlbEntryT;

endpackage
